// File: common/decode_pkg.sv
package decode_pkg;

    // ------------------------------
    // Major opcodes
    // ------------------------------
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;
    localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
    localparam logic [6:0] OPC_STORE_FP = 7'b0100111;
    localparam logic [6:0] OPC_OP_V     = 7'b1010111;

    // ------------------------------
    // Function fields
    // ------------------------------
    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    // OPIVV/OPIVX/OPIVI integer ops
    localparam logic [5:0] F6_VADD  = 6'b000000;
    localparam logic [5:0] F6_VSUB  = 6'b000010;
    localparam logic [5:0] F6_VRSUB = 6'b000011;
    localparam logic [5:0] F6_VMINU = 6'b000100;
    localparam logic [5:0] F6_VMAXU = 6'b000110;

    localparam logic [2:0] F3_OPIVV = 3'b000;
    localparam logic [2:0] F3_OPIVI = 3'b011;
    localparam logic [2:0] F3_OPIVX = 3'b100;

    // Vector memory selectors
    localparam logic [4:0] LUMOP_WHOLE = 5'b01000;

    localparam logic [2:0] VW_8  = 3'b000;
    localparam logic [2:0] VW_16 = 3'b101;
    localparam logic [2:0] VW_32 = 3'b110;
    localparam logic [2:0] VW_64 = 3'b111;

    // Fully specified system words
    localparam logic [31:0] INST_ECALL  = 32'h0000_0073;
    localparam logic [31:0] INST_EBREAK = 32'h0010_0073;
    localparam logic [31:0] INST_ERET   = 32'h3020_0073;
    localparam logic [31:0] INST_WFI    = 32'h1050_0073;

    // ------------------------------
    // Instruction word views
    // ------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [2:0] nf;
        logic       mew;
        logic [1:0] mop;
        logic       vm;
        logic [4:0] lumop;
        logic [4:0] rs1;
        logic [2:0] width;
        logic [4:0] vd;
        logic [6:0] opcode;
    } inst_vls_t;

    typedef struct packed {
        logic [5:0] funct6;
        logic       vm;
        logic [4:0] vs2;
        logic [4:0] vs1;
        logic [2:0] funct3;
        logic [4:0] vd;
        logic [6:0] opcode;
    } inst_varith_t;

    typedef union packed {
        inst_r_t      r;
        inst_vls_t    vls;
        inst_varith_t varith;
    } inst_word_u;

    // ------------------------------
    // Classification results
    // ------------------------------
    typedef struct packed {
        logic known;
        logic exec;
        logic lsu;
        logic branch;
        logic mul;
        logic div;
        logic csr_sys;
        logic rd_valid;
    } scalar_class_t;

    typedef struct packed {
        logic known;
        logic lsu_v;
        logic alu_v;
    } vector_class_t;

    typedef struct packed {
        logic invalid;
        logic exec;
        logic lsu;
        logic branch;
        logic mul;
        logic div;
        logic csr;
        logic rd_valid;
        logic lsu_v;
        logic alu_v;
    } decode_flags_t;

endpackage

// File: decode/scalar_decoder.sv
`timescale 1ns/1ns

module scalar_decoder (
    input  decode_pkg::inst_word_u    opcode_i,
    input  logic                      enable_muldiv_i,
    output decode_pkg::scalar_class_t class_o
);

    // SFENCE.VMA funct7
    localparam logic [6:0] F7_SFENCE = 7'b0001001;

    decode_pkg::inst_r_t inst;
    logic [31:0]         word;

    logic op_imm_ok;
    logic op_ok;
    logic is_exec;
    logic is_load;
    logic is_store;
    logic is_jal;
    logic is_jalr;
    logic is_bcc;
    logic is_sys_word;
    logic is_csr;
    logic is_fence;
    logic is_sfence;
    logic is_m;
    logic is_mul;
    logic is_div;

    assign inst = opcode_i.r;
    assign word = opcode_i;

    // ------------------------------
    // Integer ALU
    // ------------------------------
    // Shift immediates must carry a legal funct7
    always_comb begin
        case (inst.funct3)
            3'b001:  op_imm_ok = (inst.funct7 == decode_pkg::F7_BASE);
            3'b101:  op_imm_ok = (inst.funct7 == decode_pkg::F7_BASE) ||
                                 (inst.funct7 == decode_pkg::F7_ALT);
            default: op_imm_ok = 1'b1;
        endcase
    end

    // SUB and SRA only for the alternate form
    assign op_ok = (inst.funct7 == decode_pkg::F7_BASE) ||
                   ((inst.funct7 == decode_pkg::F7_ALT) &&
                    ((inst.funct3 == 3'b000) || (inst.funct3 == 3'b101)));

    assign is_exec = (inst.opcode == decode_pkg::OPC_LUI)   ||
                     (inst.opcode == decode_pkg::OPC_AUIPC) ||
                     ((inst.opcode == decode_pkg::OPC_OP_IMM) && op_imm_ok) ||
                     ((inst.opcode == decode_pkg::OPC_OP) && op_ok);

    // ------------------------------
    // Memory and control flow
    // ------------------------------
    // Loads skip funct3 011 and 111, 110 is LWU
    assign is_load = (inst.opcode == decode_pkg::OPC_LOAD) &&
                     (inst.funct3 != 3'b011) && (inst.funct3 != 3'b111);

    assign is_store = (inst.opcode == decode_pkg::OPC_STORE) && (inst.funct3 < 3'b011);

    assign is_jal  = (inst.opcode == decode_pkg::OPC_JAL);
    assign is_jalr = (inst.opcode == decode_pkg::OPC_JALR) && (inst.funct3 == 3'b000);

    assign is_bcc = (inst.opcode == decode_pkg::OPC_BRANCH) &&
                    (inst.funct3 != 3'b010) && (inst.funct3 != 3'b011);

    // ------------------------------
    // System, CSR and fences
    // ------------------------------
    assign is_sys_word = (word == decode_pkg::INST_ECALL)  ||
                         (word == decode_pkg::INST_EBREAK) ||
                         (word == decode_pkg::INST_ERET)   ||
                         (word == decode_pkg::INST_WFI);

    assign is_csr = (inst.opcode == decode_pkg::OPC_SYSTEM) &&
                    (inst.funct3 != 3'b000) && (inst.funct3 != 3'b100);

    // FENCE and FENCE.I
    assign is_fence = (inst.opcode == decode_pkg::OPC_MISC_MEM) && (inst.funct3[2:1] == 2'b00);

    assign is_sfence = (inst.opcode == decode_pkg::OPC_SYSTEM) && (inst.funct3 == 3'b000) &&
                       (inst.funct7 == F7_SFENCE) && (inst.rd == 5'd0);

    // ------------------------------
    // M extension
    // ------------------------------
    assign is_m   = (inst.opcode == decode_pkg::OPC_OP) && (inst.funct7 == decode_pkg::F7_MULDIV);
    assign is_mul = is_m && !inst.funct3[2];
    assign is_div = is_m && inst.funct3[2];

    assign class_o.exec    = is_exec;
    assign class_o.lsu     = is_load || is_store;
    assign class_o.branch  = is_jal || is_jalr || is_bcc;
    assign class_o.mul     = enable_muldiv_i && is_mul;
    assign class_o.div     = enable_muldiv_i && is_div;
    assign class_o.csr_sys = is_sys_word || is_csr || is_fence || is_sfence;

    assign class_o.known = is_exec || is_load || is_store || class_o.branch ||
                           class_o.csr_sys || class_o.mul || class_o.div;

    // M patterns still count as writing rd when the unit is off
    assign class_o.rd_valid = is_exec || is_load || is_jal || is_jalr || is_csr || is_m;

endmodule

// File: decode/vector_decoder.sv
`timescale 1ns/1ns

module vector_decoder (
    input  decode_pkg::inst_word_u    opcode_i,
    input  logic                      enable_vector_i,
    output decode_pkg::vector_class_t class_o
);

    decode_pkg::inst_vls_t    vls;
    decode_pkg::inst_varith_t va;

    logic nf_ok;
    logic whole_hdr;
    logic width_ok;
    logic is_vl;
    logic is_vs;
    logic form_vv;
    logic form_vx;
    logic form_vi;
    logic is_valu;

    assign vls = opcode_i.vls;
    assign va  = opcode_i.varith;

    // ------------------------------
    // Whole-register load/store
    // ------------------------------
    // Register groups of 1, 2, 4 or 8
    assign nf_ok = (vls.nf == 3'd0) || (vls.nf == 3'd1) ||
                   (vls.nf == 3'd3) || (vls.nf == 3'd7);

    assign whole_hdr = nf_ok && !vls.mew && (vls.mop == 2'b00) && vls.vm &&
                       (vls.lumop == decode_pkg::LUMOP_WHOLE);

    assign width_ok = (vls.width == decode_pkg::VW_8)  ||
                      (vls.width == decode_pkg::VW_16) ||
                      (vls.width == decode_pkg::VW_32) ||
                      (vls.width == decode_pkg::VW_64);

    assign is_vl = (vls.opcode == decode_pkg::OPC_LOAD_FP) && whole_hdr && width_ok;

    // Stores only exist with byte width
    assign is_vs = (vls.opcode == decode_pkg::OPC_STORE_FP) && whole_hdr &&
                   (vls.width == decode_pkg::VW_8);

    // ------------------------------
    // Integer ALU subset
    // ------------------------------
    assign form_vv = (va.funct3 == decode_pkg::F3_OPIVV);
    assign form_vx = (va.funct3 == decode_pkg::F3_OPIVX);
    assign form_vi = (va.funct3 == decode_pkg::F3_OPIVI);

    always_comb begin
        is_valu = 1'b0;
        if (va.opcode == decode_pkg::OPC_OP_V) begin
            case (va.funct6)
                decode_pkg::F6_VADD:  is_valu = form_vv || form_vx || form_vi;
                decode_pkg::F6_VSUB:  is_valu = form_vv || form_vx;
                decode_pkg::F6_VRSUB: is_valu = form_vx || form_vi;
                decode_pkg::F6_VMINU: is_valu = form_vv || form_vx;
                decode_pkg::F6_VMAXU: is_valu = form_vv || form_vx;
                default:              is_valu = 1'b0;
            endcase
        end
    end

    assign class_o.lsu_v = enable_vector_i && (is_vl || is_vs);
    assign class_o.alu_v = enable_vector_i && is_valu;
    assign class_o.known = class_o.lsu_v || class_o.alu_v;

endmodule

// File: src/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      valid_i,
    input  logic                      fetch_fault_i,
    input  decode_pkg::scalar_class_t scalar_i,
    input  decode_pkg::vector_class_t vector_i,
    output logic                      valid_o,
    output decode_pkg::decode_flags_t flags_o
);

    decode_pkg::decode_flags_t flags_d;
    logic                      invalid;

    // Neither decoder recognised the word
    assign invalid = valid_i && !scalar_i.known && !vector_i.known;

    always_comb begin
        flags_d.invalid  = invalid;
        flags_d.exec     = scalar_i.exec;
        flags_d.lsu      = scalar_i.lsu;
        flags_d.branch   = scalar_i.branch;
        flags_d.mul      = scalar_i.mul;
        flags_d.div      = scalar_i.div;
        // Traps go through the CSR unit
        flags_d.csr      = scalar_i.csr_sys || invalid || fetch_fault_i;
        flags_d.rd_valid = scalar_i.rd_valid;
        flags_d.lsu_v    = vector_i.lsu_v;
        flags_d.alu_v    = vector_i.alu_v;
    end

    // ------------------------------
    // Output register
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
            flags_o <= '0;
        end else begin
            valid_o <= valid_i;
            flags_o <= flags_d;
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    // Scalar and vector classes never overlap
    a_one_unit: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({flags_o.exec, flags_o.lsu, flags_o.branch, flags_o.mul,
                  flags_o.div, flags_o.lsu_v, flags_o.alu_v})
    );

    // An unrecognised word never reports an execution unit
    a_invalid_no_unit: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        flags_o.invalid |-> !(flags_o.exec || flags_o.lsu || flags_o.branch || flags_o.mul ||
                              flags_o.div || flags_o.lsu_v || flags_o.alu_v)
    );

    // M instructions always write rd
    a_muldiv_rd: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (flags_o.mul || flags_o.div) |-> flags_o.rd_valid
    );

endmodule

// File: src/decode_unit.sv
`timescale 1ns/1ns

module decode_unit (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      valid_i,
    input  logic                      fetch_fault_i,
    input  logic                      enable_muldiv_i,
    input  logic                      enable_vector_i,
    input  decode_pkg::inst_word_u    opcode_i,
    output logic                      valid_o,
    output decode_pkg::decode_flags_t flags_o
);

    decode_pkg::scalar_class_t scalar_class;
    decode_pkg::vector_class_t vector_class;

    scalar_decoder i_scalar_decoder (
        .opcode_i        (opcode_i),
        .enable_muldiv_i (enable_muldiv_i),
        .class_o         (scalar_class)
    );

    vector_decoder i_vector_decoder (
        .opcode_i        (opcode_i),
        .enable_vector_i (enable_vector_i),
        .class_o         (vector_class)
    );

    decode_stage i_decode_stage (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .valid_i       (valid_i),
        .fetch_fault_i (fetch_fault_i),
        .scalar_i      (scalar_class),
        .vector_i      (vector_class),
        .valid_o       (valid_o),
        .flags_o       (flags_o)
    );

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset released on a rising edge
    initial begin
        rst_n_o <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// File: sim/tb_decode_unit.sv
`timescale 1ns/1ns

module tb_decode_unit;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    // Reset, two scalar passes, two vector passes, fault test, random stream
    localparam int NUM_VECTORS  = RESET_CYCLES + 24 + 68 + 2 + 200;
    localparam int WATCHDOG_NS  = (NUM_VECTORS + 20) * CLK_PERIOD;

    logic                      clk;
    logic                      rst_n;
    logic                      valid_in;
    logic                      fault_in;
    logic                      en_muldiv;
    logic                      en_vector;
    decode_pkg::inst_word_u    opcode_in;
    logic                      valid_out;
    decode_pkg::decode_flags_t flags_out;

    // Word in flight, checked one cycle after it was driven
    string                     pend_name;
    logic                      pend_valid;
    decode_pkg::decode_flags_t pend_flags;
    logic                      pending = 1'b0;

    int          checks = 0;
    int          errors = 0;
    logic [31:0] lfsr   = 32'h75a2_591a;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) i_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    decode_unit i_dut (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .valid_i         (valid_in),
        .fetch_fault_i   (fault_in),
        .enable_muldiv_i (en_muldiv),
        .enable_vector_i (en_vector),
        .opcode_i        (opcode_in),
        .valid_o         (valid_out),
        .flags_o         (flags_out)
    );

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic decode_pkg::decode_flags_t model_flags(input logic [31:0] word,
            input logic vld, input logic fault, input logic en_m, input logic en_v);
        decode_pkg::inst_r_t       r;
        decode_pkg::inst_vls_t     m;
        decode_pkg::inst_varith_t  a;
        decode_pkg::decode_flags_t f;
        logic csr_sys;
        logic m_ext;
        logic whole;
        logic legal_v;
        r = word;
        m = word;
        a = word;
        f = '0;
        csr_sys = 1'b0;
        m_ext = 1'b0;
        whole = m.nf inside {3'd0, 3'd1, 3'd3, 3'd7} && !m.mew && (m.mop == 2'b00) && m.vm &&
                (m.lumop == decode_pkg::LUMOP_WHOLE);
        legal_v = 1'b0;
        case (a.funct6)
            decode_pkg::F6_VADD:
                legal_v = a.funct3 inside {decode_pkg::F3_OPIVV, decode_pkg::F3_OPIVX,
                                           decode_pkg::F3_OPIVI};
            decode_pkg::F6_VRSUB:
                legal_v = a.funct3 inside {decode_pkg::F3_OPIVX, decode_pkg::F3_OPIVI};
            decode_pkg::F6_VSUB, decode_pkg::F6_VMINU, decode_pkg::F6_VMAXU:
                legal_v = a.funct3 inside {decode_pkg::F3_OPIVV, decode_pkg::F3_OPIVX};
            default: legal_v = 1'b0;
        endcase
        case (r.opcode)
            decode_pkg::OPC_LUI, decode_pkg::OPC_AUIPC: f.exec = 1'b1;
            decode_pkg::OPC_OP_IMM: begin
                case (r.funct3)
                    3'b001:  f.exec = (r.funct7 == decode_pkg::F7_BASE);
                    3'b101:  f.exec = r.funct7 inside {decode_pkg::F7_BASE, decode_pkg::F7_ALT};
                    default: f.exec = 1'b1;
                endcase
            end
            decode_pkg::OPC_OP: begin
                m_ext  = (r.funct7 == decode_pkg::F7_MULDIV);
                f.exec = (r.funct7 == decode_pkg::F7_BASE) ||
                         ((r.funct7 == decode_pkg::F7_ALT) && r.funct3 inside {3'b000, 3'b101});
                f.mul  = en_m && m_ext && (r.funct3 < 3'd4);
                f.div  = en_m && m_ext && (r.funct3 >= 3'd4);
            end
            decode_pkg::OPC_LOAD:   f.lsu = !(r.funct3 inside {3'b011, 3'b111});
            decode_pkg::OPC_STORE:  f.lsu = r.funct3 inside {3'b000, 3'b001, 3'b010};
            decode_pkg::OPC_JAL:    f.branch = 1'b1;
            decode_pkg::OPC_JALR:   f.branch = (r.funct3 == 3'b000);
            decode_pkg::OPC_BRANCH: f.branch = !(r.funct3 inside {3'b010, 3'b011});
            decode_pkg::OPC_MISC_MEM: csr_sys = r.funct3 inside {3'b000, 3'b001};
            decode_pkg::OPC_SYSTEM: begin
                if (r.funct3 == 3'b000) begin
                    csr_sys = word inside {decode_pkg::INST_ECALL, decode_pkg::INST_EBREAK,
                                           decode_pkg::INST_ERET, decode_pkg::INST_WFI} ||
                              ((r.funct7 == 7'b0001001) && (r.rd == 5'd0));
                end else if (r.funct3 != 3'b100) begin
                    csr_sys    = 1'b1;
                    f.rd_valid = 1'b1;
                end
            end
            decode_pkg::OPC_LOAD_FP:
                f.lsu_v = en_v && whole && m.width inside {decode_pkg::VW_8, decode_pkg::VW_16,
                                                           decode_pkg::VW_32, decode_pkg::VW_64};
            decode_pkg::OPC_STORE_FP: f.lsu_v = en_v && whole && (m.width == decode_pkg::VW_8);
            decode_pkg::OPC_OP_V:     f.alu_v = en_v && legal_v;
            default: ;
        endcase
        // Stores and branches other than JAL/JALR leave rd alone
        if (r.opcode != decode_pkg::OPC_STORE && r.opcode != decode_pkg::OPC_BRANCH) begin
            f.rd_valid = f.rd_valid || f.exec || f.lsu || f.branch || m_ext;
        end
        f.invalid = vld && !(f.exec || f.lsu || f.branch || f.mul || f.div || csr_sys ||
                             f.lsu_v || f.alu_v);
        f.csr     = csr_sys || f.invalid || fault;
        return f;
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic next_bits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] vls_word(input logic [6:0] opc, input logic [2:0] nf,
                                              input logic [2:0] width);
        decode_pkg::inst_vls_t v;
        v        = '0;
        v.nf     = nf;
        v.vm     = 1'b1;
        v.lumop  = decode_pkg::LUMOP_WHOLE;
        v.rs1    = 5'd10;
        v.width  = width;
        v.vd     = 5'd8;
        v.opcode = opc;
        return v;
    endfunction

    function automatic logic [31:0] varith_word(input logic [5:0] funct6, input logic [2:0] funct3);
        decode_pkg::inst_varith_t v;
        v        = '0;
        v.funct6 = funct6;
        v.vm     = 1'b1;
        v.vs2    = 5'd2;
        v.vs1    = 5'd3;
        v.funct3 = funct3;
        v.vd     = 5'd1;
        v.opcode = decode_pkg::OPC_OP_V;
        return v;
    endfunction

    // ------------------------------
    // Drive and compare
    // ------------------------------
    task automatic compare_flags(input string name, input decode_pkg::decode_flags_t exp,
                                 input decode_pkg::decode_flags_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s flags: expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic compare_valid(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s valid: expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_pending();
        if (pending) begin
            compare_valid(pend_name, pend_valid, valid_out);
            compare_flags(pend_name, pend_flags, flags_out);
        end
    endtask

    task automatic drive_word(input string name, input logic [31:0] word, input logic vld,
                              input logic fault, input logic en_m, input logic en_v);
        @(posedge clk);
        valid_in  <= vld;
        fault_in  <= fault;
        en_muldiv <= en_m;
        en_vector <= en_v;
        opcode_in <= word;
        @(negedge clk);
        check_pending();
        pend_name  = name;
        pend_valid = vld;
        pend_flags = model_flags(word, vld, fault, en_m, en_v);
        pending    = 1'b1;
    endtask

    task automatic drain_pipeline();
        @(posedge clk);
        valid_in <= 1'b0;
        fault_in <= 1'b0;
        @(negedge clk);
        check_pending();
        pending = 1'b0;
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic test_reset();
        // Illegal faulting word while reset is still held
        @(posedge clk);
        valid_in  <= 1'b1;
        fault_in  <= 1'b1;
        opcode_in <= 32'hffff_ffff;
        @(posedge clk);
        @(negedge clk);
        compare_valid("reset", 1'b0, valid_out);
        compare_flags("reset", '0, flags_out);
        @(posedge clk);
        valid_in  <= 1'b0;
        fault_in  <= 1'b0;
        opcode_in <= '0;
        while (!rst_n) @(posedge clk);
    endtask

    task automatic scalar_pass(input logic en_m);
        drive_word("ADD",    32'h0031_00b3, 1'b1, 1'b0, en_m, 1'b0);
        drive_word("SRAI",   32'h4033_5293, 1'b1, 1'b0, en_m, 1'b0);
        drive_word("LUI",    32'h1234_53b7, 1'b1, 1'b0, en_m, 1'b0);
        drive_word("LWU",    32'h0044_e403, 1'b1, 1'b0, en_m, 1'b0);
        drive_word("SW",     32'h00a5_a423, 1'b1, 1'b0, en_m, 1'b0);
        drive_word("JALR",   32'h0002_80e7, 1'b1, 1'b0, en_m, 1'b0);
        drive_word("BGEU",   32'h0020_f863, 1'b1, 1'b0, en_m, 1'b0);
        drive_word("CSRRCI", 32'h3002_f1f3, 1'b1, 1'b0, en_m, 1'b0);
        drive_word("ECALL",  32'h0000_0073, 1'b1, 1'b0, en_m, 1'b0);
        drive_word("FENCE",  32'h0ff0_000f, 1'b1, 1'b0, en_m, 1'b0);
        drive_word("MUL",    32'h0231_00b3, 1'b1, 1'b0, en_m, 1'b0);
        drive_word("REMU",   32'h0262_f233, 1'b1, 1'b0, en_m, 1'b0);
        drain_pipeline();
    endtask

    task automatic test_scalar_classes();
        scalar_pass(1'b1);
        scalar_pass(1'b0);
    endtask

    task automatic vector_pass(input logic en_v);
        logic [2:0] nfs [4];
        logic [2:0] widths [4];
        logic [5:0] f6s [11];
        logic [2:0] f3s [11];
        nfs    = '{3'd0, 3'd1, 3'd3, 3'd7};
        widths = '{decode_pkg::VW_8, decode_pkg::VW_16, decode_pkg::VW_32, decode_pkg::VW_64};
        f6s    = '{decode_pkg::F6_VADD, decode_pkg::F6_VADD, decode_pkg::F6_VADD,
                   decode_pkg::F6_VSUB, decode_pkg::F6_VSUB, decode_pkg::F6_VRSUB,
                   decode_pkg::F6_VRSUB, decode_pkg::F6_VMINU, decode_pkg::F6_VMINU,
                   decode_pkg::F6_VMAXU, decode_pkg::F6_VMAXU};
        f3s    = '{decode_pkg::F3_OPIVV, decode_pkg::F3_OPIVX, decode_pkg::F3_OPIVI,
                   decode_pkg::F3_OPIVV, decode_pkg::F3_OPIVX, decode_pkg::F3_OPIVX,
                   decode_pkg::F3_OPIVI, decode_pkg::F3_OPIVV, decode_pkg::F3_OPIVX,
                   decode_pkg::F3_OPIVV, decode_pkg::F3_OPIVX};
        foreach (nfs[i]) begin
            foreach (widths[j]) begin
                drive_word($sformatf("VL nf%0d w%0d", nfs[i], widths[j]),
                           vls_word(decode_pkg::OPC_LOAD_FP, nfs[i], widths[j]),
                           1'b1, 1'b0, 1'b0, en_v);
            end
            drive_word($sformatf("VS nf%0d", nfs[i]),
                       vls_word(decode_pkg::OPC_STORE_FP, nfs[i], decode_pkg::VW_8),
                       1'b1, 1'b0, 1'b0, en_v);
        end
        for (int k = 0; k < 11; k++) begin
            drive_word($sformatf("VALU f6 %0d f3 %0d", f6s[k], f3s[k]),
                       varith_word(f6s[k], f3s[k]), 1'b1, 1'b0, 1'b0, en_v);
        end
        // Illegal neighbours
        drive_word("VSUB VI", varith_word(decode_pkg::F6_VSUB, decode_pkg::F3_OPIVI),
                   1'b1, 1'b0, 1'b0, en_v);
        drive_word("VL nf2", vls_word(decode_pkg::OPC_LOAD_FP, 3'd2, decode_pkg::VW_8),
                   1'b1, 1'b0, 1'b0, en_v);
        drive_word("VS w16", vls_word(decode_pkg::OPC_STORE_FP, 3'd0, decode_pkg::VW_16),
                   1'b1, 1'b0, 1'b0, en_v);
        drain_pipeline();
    endtask

    task automatic test_vector_classes();
        vector_pass(1'b1);
        vector_pass(1'b0);
    endtask

    task automatic test_fault_and_valid();
        drive_word("ADD fault", 32'h0031_00b3, 1'b1, 1'b1, 1'b1, 1'b1);
        drive_word("illegal idle", 32'hffff_ffff, 1'b0, 1'b0, 1'b1, 1'b1);
        drain_pipeline();
    endtask

    task automatic test_random_stream();
        logic [31:0] word;
        logic [31:0] ctl;
        for (int i = 0; i < 200; i++) begin
            next_bits(32, word);
            next_bits(3, ctl);
            drive_word($sformatf("random %0d", i), word, ctl[0], 1'b0, ctl[1], ctl[2]);
        end
        drain_pipeline();
    endtask

    // ------------------------------
    // Main sequence and watchdog
    // ------------------------------
    initial begin
        valid_in  <= 1'b0;
        fault_in  <= 1'b0;
        en_muldiv <= 1'b0;
        en_vector <= 1'b0;
        opcode_in <= '0;
        test_reset();
        test_scalar_classes();
        test_vector_classes();
        test_fault_and_valid();
        test_random_stream();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the test sequence did not finish", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: decode_unit.f
common/decode_pkg.sv
decode/scalar_decoder.sv
decode/vector_decoder.sv
src/decode_stage.sv
src/decode_unit.sv
sim/tb_clock_gen.sv
sim/tb_decode_unit.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_decode_unit
FILELIST  = decode_unit.f
BUILD_DIR = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
